// File: hdl/boot_loader.sv
`timescale 1ns/1ps
`default_nettype none

module boot_loader (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  [7:0]                       rx_byte,
    input  wire                              rx_strobe,
    output logic                             start_program,
    output logic                             program_done,
    output logic [uart_pkg::word_width-1:0]  flash_addr,
    output logic [uart_pkg::word_width-1:0]  flash_data,
    output logic                             flash_we
);

    // states 0 to 3 wait for marker byte n, 4 loads words
    localparam logic [2:0] st_hunt = 3'd0;
    localparam logic [2:0] st_last = 3'd3;
    localparam logic [2:0] st_load = 3'd4;

    logic [2:0] state;
    // bytes already packed into the current word
    logic [1:0] byte_cnt;
    logic [uart_pkg::word_width-1:0] word_reg;
    logic [uart_pkg::word_width-1:0] word_next;
    logic       loading;
    logic       word_done;

    assign loading   = (state == st_load);
    // big-endian, first byte ends up on top
    assign word_next = {word_reg[uart_pkg::word_width-9:0], rx_byte};
    assign word_done = rx_strobe && loading && (byte_cnt == 2'd3);

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_hunt;
            byte_cnt      <= '0;
            start_program <= 1'b0;
            program_done  <= 1'b0;
            flash_we      <= 1'b0;
            flash_addr    <= '0;
        end else begin
            start_program <= 1'b0;
            program_done  <= 1'b0;
            flash_we      <= 1'b0;
            // advance once the write has gone out
            if (flash_we) begin
                flash_addr <= flash_addr + 1'b1;
            end
            if (rx_strobe) begin
                if (loading) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (word_done) begin
                        if (word_next == uart_pkg::end_marker_word) begin
                            // end word itself is never written
                            program_done <= 1'b1;
                            state        <= st_hunt;
                        end else begin
                            flash_we <= 1'b1;
                        end
                    end
                end else if (rx_byte == uart_pkg::start_marker[state[1:0]]) begin
                    if (state == st_last) begin
                        state         <= st_load;
                        start_program <= 1'b1;
                        byte_cnt      <= '0;
                        flash_addr    <= '0;
                    end else begin
                        state <= state + 3'd1;
                    end
                end else begin
                    // mismatch, back to hunting for 5a
                    state <= st_hunt;
                end
            end
        end
    end

    // word assembly
    always_ff @(posedge clk) begin
        if (rx_strobe && loading) begin
            word_reg <= word_next;
        end
        if (word_done) begin
            flash_data <= word_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_loader.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loader #(
    parameter logic [uart_pkg::word_width-1:0] reset_divisor = 159
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              wb_cyc,
    input  wire                              wb_stb,
    input  wire                              wb_we,
    input  wire  [1:0]                       wb_adr,
    input  wire  [uart_pkg::word_width-1:0]  wb_dat_w,
    output logic [uart_pkg::word_width-1:0]  wb_dat_r,
    output logic                             wb_ack,
    input  wire                              uart_rx,
    output logic                             uart_tx,
    output logic                             rx_int_req,
    output logic                             start_program,
    output logic                             program_done,
    output logic [uart_pkg::word_width-1:0]  flash_addr,
    output logic [uart_pkg::word_width-1:0]  flash_data,
    output logic                             flash_we
);

    // register block to transmitter
    logic                 tx_start;
    logic [7:0]           tx_byte;
    logic                 tx_enable;
    logic                 tx_busy;
    uart_pkg::baud_word_u baud;
    // receiver to register block and loader
    logic [7:0]           rx_byte;
    logic                 rx_strobe;
    logic                 rx_busy;

    uart_regs #(
        .reset_divisor(reset_divisor)
    ) regs (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .tx_busy(tx_busy), .rx_busy(rx_busy),
        .rx_strobe(rx_strobe), .rx_byte(rx_byte), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack), .tx_start(tx_start), .tx_byte(tx_byte),
        .tx_enable(tx_enable), .baud(baud), .rx_int_req(rx_int_req)
    );

    uart_tx tx_unit (
        .clk(clk), .reset(reset), .tx_start(tx_start), .tx_byte(tx_byte),
        .tx_enable(tx_enable), .baud(baud), .tx_busy(tx_busy), .uart_tx(uart_tx)
    );

    uart_rx rx_unit (
        .clk(clk), .reset(reset), .uart_rx(uart_rx), .baud(baud),
        .rx_byte(rx_byte), .rx_strobe(rx_strobe), .rx_busy(rx_busy)
    );

    // loader sees every good byte, no back-pressure
    boot_loader loader (
        .clk(clk), .reset(reset), .rx_byte(rx_byte), .rx_strobe(rx_strobe),
        .start_program(start_program), .program_done(program_done),
        .flash_addr(flash_addr), .flash_data(flash_data), .flash_we(flash_we)
    );

endmodule

`default_nettype wire

// File: hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // bus and flash word width
    localparam int word_width = 32;

    // word indices on wb_adr
    localparam logic [1:0] csr_addr     = 2'd0;
    localparam logic [1:0] baud_addr    = 2'd1;
    localparam logic [1:0] tx_data_addr = 2'd2;
    localparam logic [1:0] rx_data_addr = 2'd3;

    // control/status bits, busy bits are read-only
    localparam int tx_enable_bit     = 0;
    localparam int tx_busy_bit       = 2;
    localparam int rx_busy_bit       = 3;
    localparam int rx_int_enable_bit = 4;

    // receiver oversampling and frame timing
    localparam int ticks_per_bit    = 16;
    localparam int sample_offset    = 6;
    localparam int false_start_tick = 14;
    localparam int frame_ticks      = 160;

    // boot loader markers, index 0 arrives first
    localparam logic [0:3][7:0] start_marker = {8'h5a, 8'ha5, 8'h0f, 8'hf0};
    localparam logic [word_width-1:0] end_marker_word = 32'hf00fa55a;

    // baud word, one view per direction
    // rx tick divisor is the tx bit divisor over 16
    typedef union packed {
        struct packed {
            logic [15:0] upper;
            logic [15:0] bit_div;
        } tx;
        struct packed {
            logic [18:0] upper;
            logic [8:0]  tick_div;
            logic [3:0]  frac;
        } rx;
    } baud_word_u;

endpackage

`default_nettype wire

// File: hdl/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs #(
    parameter logic [uart_pkg::word_width-1:0] reset_divisor = 159
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              wb_cyc,
    input  wire                              wb_stb,
    input  wire                              wb_we,
    input  wire  [1:0]                       wb_adr,
    input  wire  [uart_pkg::word_width-1:0]  wb_dat_w,
    input  wire                              tx_busy,
    input  wire                              rx_busy,
    input  wire                              rx_strobe,
    input  wire  [7:0]                       rx_byte,
    output logic [uart_pkg::word_width-1:0]  wb_dat_r,
    output logic                             wb_ack,
    output logic                             tx_start,
    output logic [7:0]                       tx_byte,
    output logic                             tx_enable,
    output uart_pkg::baud_word_u             baud,
    output logic                             rx_int_req
);

    // new request, ack low so each access takes two cycles
    logic req;
    logic rx_int_enable;
    // last good received byte
    logic [7:0] rx_last;
    // status view with live busy flags
    logic [uart_pkg::word_width-1:0] csr_view;

    assign req = wb_cyc && wb_stb && !wb_ack;

    always_comb begin
        csr_view = '0;
        csr_view[uart_pkg::tx_enable_bit]     = tx_enable;
        csr_view[uart_pkg::tx_busy_bit]       = tx_busy;
        csr_view[uart_pkg::rx_busy_bit]       = rx_busy;
        csr_view[uart_pkg::rx_int_enable_bit] = rx_int_enable;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack        <= 1'b0;
            tx_start      <= 1'b0;
            tx_enable     <= 1'b0;
            rx_int_enable <= 1'b0;
            rx_int_req    <= 1'b0;
            baud          <= reset_divisor;
        end else begin
            wb_ack     <= req;
            // transmit kick lines up with the ack
            tx_start   <= req && wb_we && (wb_adr == uart_pkg::tx_data_addr);
            // one pulse per good byte
            rx_int_req <= rx_strobe && rx_int_enable;
            if (req && wb_we) begin
                case (wb_adr)
                    uart_pkg::csr_addr: begin
                        tx_enable     <= wb_dat_w[uart_pkg::tx_enable_bit];
                        rx_int_enable <= wb_dat_w[uart_pkg::rx_int_enable_bit];
                    end
                    uart_pkg::baud_addr: begin
                        baud <= wb_dat_w;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // data registers and read mux
    always_ff @(posedge clk) begin
        if (req && wb_we && (wb_adr == uart_pkg::tx_data_addr)) begin
            tx_byte <= wb_dat_w[7:0];
        end
        if (rx_strobe) begin
            rx_last <= rx_byte;
        end
        if (req) begin
            case (wb_adr)
                uart_pkg::csr_addr:     wb_dat_r <= csr_view;
                uart_pkg::baud_addr:    wb_dat_r <= baud;
                uart_pkg::tx_data_addr: wb_dat_r <= {{(uart_pkg::word_width-8){1'b0}}, tx_byte};
                uart_pkg::rx_data_addr: wb_dat_r <= {{(uart_pkg::word_width-8){1'b0}}, rx_last};
                default:                wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   uart_rx,
    input  wire uart_pkg::baud_word_u baud,
    output logic [7:0]            rx_byte,
    output logic                  rx_strobe,
    output logic                  rx_busy
);

    // two-flop synchronizer plus edge history
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic [8:0] div_cnt;
    // 0 to 159 across the frame
    logic [7:0] tick_cnt;
    logic [3:0] slot;
    logic [3:0] pos;
    logic       tick;
    logic       in_window;
    logic       vote_end;
    logic [1:0] vote;
    logic [1:0] vote_next;
    logic [7:0] shift;

    assign tick      = rx_busy && (div_cnt == baud.rx.tick_div);
    assign slot      = 4'(tick_cnt / uart_pkg::ticks_per_bit);
    assign pos       = 4'(tick_cnt % uart_pkg::ticks_per_bit);
    assign in_window = (pos >= 4'(uart_pkg::sample_offset))
                    && (pos <= 4'(uart_pkg::sample_offset + 2));
    assign vote_end  = (pos == 4'(uart_pkg::sample_offset + 2));
    // first sample of a slot restarts the sum
    assign vote_next = ((pos == 4'(uart_pkg::sample_offset)) ? 2'd0 : vote)
                     + {1'b0, rx_sync};

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_busy   <= 1'b0;
            rx_strobe <= 1'b0;
            div_cnt   <= '0;
            tick_cnt  <= '0;
        end else begin
            rx_strobe <= 1'b0;
            if (!rx_busy) begin
                // falling edge opens a frame
                if (rx_prev && !rx_sync) begin
                    rx_busy  <= 1'b1;
                    div_cnt  <= '0;
                    tick_cnt <= '0;
                end
            end else if (tick) begin
                div_cnt  <= '0;
                tick_cnt <= tick_cnt + 8'd1;
                if ((tick_cnt == 8'(uart_pkg::false_start_tick)) && vote[1]) begin
                    // start bit voted high, glitch
                    rx_busy <= 1'b0;
                end else if (tick_cnt == 8'(uart_pkg::frame_ticks - 1)) begin
                    rx_busy <= 1'b0;
                    // all three stop samples must be high
                    rx_strobe <= (vote == 2'd3);
                end
            end else begin
                div_cnt <= div_cnt + 9'd1;
            end
        end
    end

    // majority vote and data capture
    always_ff @(posedge clk) begin
        if (tick && in_window) begin
            vote <= vote_next;
        end
        // data slots 1 to 8, lsb arrives first
        if (tick && vote_end && (slot >= 4'd1) && (slot <= 4'd8)) begin
            shift <= {vote_next[1], shift[7:1]};
        end
        if (tick && (tick_cnt == 8'(uart_pkg::frame_ticks - 1)) && (vote == 2'd3)) begin
            rx_byte <= shift;
        end
    end

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   tx_start,
    input  wire  [7:0]            tx_byte,
    input  wire                   tx_enable,
    input  wire uart_pkg::baud_word_u baud,
    output logic                  tx_busy,
    output logic                  uart_tx
);

    logic [15:0] div_cnt;
    // bits still to send after the current one
    logic [3:0]  bits_left;
    // stop, data, start; bit 0 is on the line
    logic [9:0]  frame;
    logic        line;
    logic        bit_end;

    assign bit_end = (div_cnt == baud.tx.bit_div);
    // disabled transmitter holds the line idle
    assign uart_tx = line | !tx_enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_busy   <= 1'b0;
            line      <= 1'b1;
            div_cnt   <= '0;
            bits_left <= '0;
        end else if (!tx_enable) begin
            // abort any frame in flight
            tx_busy <= 1'b0;
            line    <= 1'b1;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy   <= 1'b1;
                line      <= 1'b0;
                div_cnt   <= '0;
                bits_left <= 4'd9;
            end
        end else if (bit_end) begin
            div_cnt <= '0;
            if (bits_left == 4'd0) begin
                // stop bit done
                tx_busy <= 1'b0;
            end else begin
                bits_left <= bits_left - 4'd1;
                line      <= frame[1];
            end
        end else begin
            div_cnt <= div_cnt + 16'd1;
        end
    end

    // shift register, lsb first
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            frame <= {1'b1, tx_byte, 1'b0};
        end else if (tx_busy && bit_end) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the uart_loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module uart_loader_tb \
    -f uart_loader.f --Mdir obj_dir -o uart_loader_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/uart_loader_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

// File: test/uart_loader_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loader_checker (
    input wire clk,
    input wire reset,
    input wire wb_cyc,
    input wire wb_stb,
    input wire wb_ack,
    input wire tx_enable,
    input wire uart_tx,
    input wire flash_we,
    input wire start_program,
    input wire program_done
);

    // running count of assertion failures
    int unsigned fail_count = 0;

    // ack only answers a request seen the cycle before
    ack_follows_request: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
        fail_count++;
        $error("wb_ack raised without wb_cyc and wb_stb");
    end

    // single-cycle ack
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
    else begin
        fail_count++;
        $error("wb_ack held for two cycles");
    end

    // flash strobe never shares a cycle with the loader pulses
    flash_we_alone: assert property (@(posedge clk) disable iff (reset)
        !(flash_we && (start_program || program_done)))
    else begin
        fail_count++;
        $error("flash_we coincides with start_program or program_done");
    end

    // disabled transmitter keeps the line idle
    tx_idle_when_disabled: assert property (@(posedge clk) disable iff (reset)
        !tx_enable |-> uart_tx)
    else begin
        fail_count++;
        $error("uart_tx low while tx_enable is low");
    end

endmodule

bind uart_loader uart_loader_checker checks (
    .clk(clk),
    .reset(reset),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_ack(wb_ack),
    .tx_enable(tx_enable),
    .uart_tx(uart_tx),
    .flash_we(flash_we),
    .start_program(start_program),
    .program_done(program_done)
);

`default_nettype wire

// File: test/uart_loader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loader_tb;

    // divisor 159 gives 160 clocks per bit
    localparam int bit_clocks = 160;
    localparam int frame_clocks = 10 * bit_clocks;
    // idle high time after each stop bit
    localparam int idle_gap = 20;
    // roughly 35 frames of traffic plus margin
    localparam int timeout_cycles = 50 * frame_clocks;

    logic        clk = 1'b0;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        rx_line;
    logic        uart_tx;
    logic        rx_int_req;
    logic        start_program;
    logic        program_done;
    logic        flash_we;
    logic [31:0] flash_addr;
    logic [31:0] flash_data;

    int          errors = 0;
    int          cycle_count = 0;
    int          int_pulses = 0;
    int          start_pulses = 0;
    int          done_pulses = 0;
    logic [31:0] flash_addr_q[$];
    logic [31:0] flash_data_q[$];
    logic [31:0] rng = 32'h4c9d;
    logic [31:0] bus_data;
    logic [31:0] words[4];

    uart_loader #(
        .reset_divisor(159)
    ) dut (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .uart_rx(rx_line), .uart_tx(uart_tx), .rx_int_req(rx_int_req),
        .start_program(start_program), .program_done(program_done),
        .flash_addr(flash_addr), .flash_data(flash_data), .flash_we(flash_we)
    );

    always #4 clk = ~clk;

    // pulse counters and flash write log
    always @(posedge clk) begin
        if (rx_int_req) int_pulses++;
        if (start_program) start_pulses++;
        if (program_done) done_pulses++;
        if (flash_we) begin
            flash_addr_q.push_back(flash_addr);
            flash_data_q.push_back(flash_data);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            finish_run(1'b1);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected)
        else begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    task automatic finish_run(input logic timed_out);
        int assert_fails;
        assert_fails = dut.checks.fail_count;
        $display("errors: %0d value checks, %0d bound assertions, %0d timeouts",
                 errors, assert_fails, timed_out);
        if (errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    // one Wishbone classic access, returns on a falling edge
    task automatic bus_access(input logic we, input logic [1:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge clk);
        while (!wb_ack && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) report_failure("bus access was not acknowledged");
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_write(input logic [1:0] adr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdata, unused);
    endtask

    task automatic bus_read(input logic [1:0] adr, output logic [31:0] rdata);
        bus_access(1'b0, adr, 32'h0, rdata);
    endtask

    // 8N1 frame, lsb first, optional broken stop bit
    task automatic send_frame(input logic [7:0] data, input logic stop_ok);
        logic [9:0] bits;
        int i;
        bits = {stop_ok, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_line <= bits[i];
            repeat (bit_clocks - 1) @(posedge clk);
        end
        @(posedge clk);
        rx_line <= 1'b1;
        repeat (idle_gap) @(posedge clk);
    endtask

    // big-endian byte order
    task automatic send_word(input logic [31:0] w);
        send_frame(w[31:24], 1'b1);
        send_frame(w[23:16], 1'b1);
        send_frame(w[15:8], 1'b1);
        send_frame(w[7:0], 1'b1);
    endtask

    // poll the status register until the receiver goes idle
    task automatic wait_rx_idle();
        logic [31:0] status;
        status = '1;
        while (status[uart_pkg::rx_busy_bit]) bus_read(uart_pkg::csr_addr, status);
    endtask

    // mid-bit samples of one transmitted frame
    task automatic capture_tx_frame(input logic [7:0] expected);
        int waited;
        int i;
        waited = 0;
        @(negedge clk);
        while (uart_tx !== 1'b0 && waited < 4 * bit_clocks) begin
            @(negedge clk);
            waited++;
        end
        if (uart_tx !== 1'b0) begin
            report_failure("no start bit seen on uart_tx");
        end else begin
            repeat (bit_clocks / 2) @(negedge clk);
            check_value("uart_tx start bit", uart_tx, 32'h0);
            for (i = 0; i < 8; i++) begin
                repeat (bit_clocks) @(negedge clk);
                check_value($sformatf("uart_tx data bit %0d", i), uart_tx, expected[i]);
            end
            repeat (bit_clocks) @(negedge clk);
            check_value("uart_tx stop bit", uart_tx, 32'h1);
        end
    endtask

    initial begin
        logic [7:0]  tx_value;
        logic [7:0]  kept_byte;
        logic [31:0] csr_ctrl;
        logic        line_dropped;
        int          pulses_before;
        int          i;

        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_w = 32'h0;
        rx_line  = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // reset values
        check_value("wb_ack", wb_ack, 32'h0);
        check_value("rx_int_req", rx_int_req, 32'h0);
        check_value("start_program", start_program, 32'h0);
        check_value("program_done", program_done, 32'h0);
        check_value("flash_we", flash_we, 32'h0);
        check_value("uart_tx", uart_tx, 32'h1);
        bus_read(uart_pkg::csr_addr, bus_data);
        check_value("csr after reset", bus_data, 32'h0);
        bus_read(uart_pkg::baud_addr, bus_data);
        check_value("baud after reset", bus_data, 32'd159);

        // register access, only the two enable bits are kept
        csr_ctrl = (32'h1 << uart_pkg::tx_enable_bit) | (32'h1 << uart_pkg::rx_int_enable_bit);
        bus_write(uart_pkg::csr_addr, 32'hffff_ffff);
        bus_read(uart_pkg::csr_addr, bus_data);
        check_value("csr readback", bus_data, csr_ctrl);
        rng = xorshift(rng);
        bus_write(uart_pkg::baud_addr, rng);
        bus_read(uart_pkg::baud_addr, bus_data);
        check_value("baud readback", bus_data, rng);
        bus_write(uart_pkg::baud_addr, 32'd159);
        bus_write(uart_pkg::csr_addr, 32'h0);
        bus_read(uart_pkg::csr_addr, bus_data);
        check_value("csr cleared", bus_data, 32'h0);

        // transmit with busy flag read mid-frame
        bus_write(uart_pkg::csr_addr, 32'h1 << uart_pkg::tx_enable_bit);
        rng = xorshift(rng);
        tx_value = rng[7:0];
        bus_write(uart_pkg::tx_data_addr, {24'h0, tx_value});
        fork
            capture_tx_frame(tx_value);
            begin
                logic [31:0] status;
                repeat (3 * bit_clocks) @(posedge clk);
                bus_read(uart_pkg::csr_addr, status);
                check_value("csr tx_busy during frame", status[uart_pkg::tx_busy_bit], 32'h1);
            end
        join
        repeat (bit_clocks) @(negedge clk);
        bus_read(uart_pkg::csr_addr, bus_data);
        check_value("csr after frame", bus_data, 32'h1 << uart_pkg::tx_enable_bit);

        // disabled transmitter ignores a write
        bus_write(uart_pkg::csr_addr, 32'h0);
        rng = xorshift(rng);
        bus_write(uart_pkg::tx_data_addr, {24'h0, rng[7:0]});
        line_dropped = 1'b0;
        repeat (2 * bit_clocks) begin
            @(negedge clk);
            if (uart_tx !== 1'b1) line_dropped = 1'b1;
        end
        check_value("uart_tx low while disabled", line_dropped, 32'h0);

        // receive with interrupt on, then off
        bus_write(uart_pkg::csr_addr, 32'h1 << uart_pkg::rx_int_enable_bit);
        pulses_before = int_pulses;
        rng = xorshift(rng);
        send_frame(rng[7:0], 1'b1);
        wait_rx_idle();
        bus_read(uart_pkg::rx_data_addr, bus_data);
        check_value("rx data", bus_data, {24'h0, rng[7:0]});
        check_value("rx_int_req pulses", int_pulses - pulses_before, 32'd1);
        bus_write(uart_pkg::csr_addr, 32'h0);
        pulses_before = int_pulses;
        rng = xorshift(rng);
        kept_byte = rng[7:0];
        send_frame(kept_byte, 1'b1);
        wait_rx_idle();
        bus_read(uart_pkg::rx_data_addr, bus_data);
        check_value("rx data, interrupt off", bus_data, {24'h0, kept_byte});
        check_value("rx_int_req pulses, interrupt off", int_pulses - pulses_before, 32'd0);

        // bad stop bit, then a short glitch
        bus_write(uart_pkg::csr_addr, 32'h1 << uart_pkg::rx_int_enable_bit);
        pulses_before = int_pulses;
        rng = xorshift(rng);
        send_frame(rng[7:0], 1'b0);
        wait_rx_idle();
        @(posedge clk);
        rx_line <= 1'b0;
        repeat (20) @(posedge clk);
        rx_line <= 1'b1;
        wait_rx_idle();
        bus_read(uart_pkg::rx_data_addr, bus_data);
        check_value("rx data after bad frames", bus_data, {24'h0, kept_byte});
        check_value("rx_int_req pulses, bad frames", int_pulses - pulses_before, 32'd0);

        // broken start marker, rest of the marker still follows
        send_frame(uart_pkg::start_marker[0], 1'b1);
        send_frame(uart_pkg::start_marker[1], 1'b1);
        send_frame(8'h33, 1'b1);
        send_frame(uart_pkg::start_marker[2], 1'b1);
        send_frame(uart_pkg::start_marker[3], 1'b1);
        @(negedge clk);
        check_value("start_program after broken marker", start_pulses, 32'd0);

        // full load, four words then the end word
        for (i = 0; i < 4; i++) begin
            send_frame(uart_pkg::start_marker[i], 1'b1);
        end
        for (i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            while (rng == uart_pkg::end_marker_word) rng = xorshift(rng);
            words[i] = rng;
            send_word(rng);
        end
        send_word(uart_pkg::end_marker_word);
        while (done_pulses == 0) @(negedge clk);
        repeat (4) @(negedge clk);
        check_value("start_program pulses", start_pulses, 32'd1);
        check_value("program_done pulses", done_pulses, 32'd1);
        check_value("flash write count", flash_addr_q.size(), 32'd4);
        for (i = 0; i < 4 && i < flash_addr_q.size(); i++) begin
            check_value($sformatf("flash_addr %0d", i), flash_addr_q[i], i);
            check_value($sformatf("flash_data %0d", i), flash_data_q[i], words[i]);
        end

        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// File: uart_loader.f
hdl/uart_pkg.sv
hdl/uart_regs.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/boot_loader.sv
hdl/uart_loader.sv
test/uart_loader_checker.sv
test/uart_loader_tb.sv
